//--- huff_defs.svh
`ifndef HUFF_DEFS_SVH
`define HUFF_DEFS_SVH

// lanes looked up side by side each cycle
`define HUFF_LANES 2

// run and size fields
`define HUFF_SIZE_W 4

// code length, 0 means no code
`define HUFF_LEN_W 5

// code word, MSB-aligned
`define HUFF_CODE_W 16

// DC categories 0..11, anything above is outside the table
`define HUFF_DC_MAX 11
`define HUFF_DC_CATS (`HUFF_DC_MAX + 1)

// AC key is {chroma, size, run}
`define HUFF_AC_KEY_W (1 + 2 * `HUFF_SIZE_W)

`endif

//--- huff_pkg.sv
package huff_pkg;

`include "huff_defs.svh"

typedef logic [`HUFF_SIZE_W-1:0] nibble_t;   // run or size
typedef logic [`HUFF_LEN_W-1:0]  code_len_t;
typedef logic [`HUFF_CODE_W-1:0] code_word_t; // zeros below the code

// one table result, 21 bits
typedef struct packed {
    code_len_t  len;
    code_word_t code;
} huff_entry_t;

// per-lane arrays
typedef nibble_t     nibble_lanes_t [`HUFF_LANES];
typedef code_len_t   len_lanes_t    [`HUFF_LANES];
typedef code_word_t  code_lanes_t   [`HUFF_LANES];
typedef huff_entry_t entry_lanes_t  [`HUFF_LANES];
typedef logic        flag_lanes_t   [`HUFF_LANES];

endpackage

//--- huff_dc_table.sv
`timescale 1ns/1ps
`include "huff_defs.svh"

module huff_dc_table (
    input  huff_pkg::nibble_lanes_t size,
    input  logic                    chroma,
    output huff_pkg::entry_lanes_t  entry
);

    // luma DC codes, indexed by category
    localparam huff_pkg::huff_entry_t DC_Y [`HUFF_DC_CATS] = '{
        {5'd2, 16'b00_00000000000000},
        {5'd3, 16'b010_0000000000000},
        {5'd3, 16'b011_0000000000000},
        {5'd3, 16'b100_0000000000000},
        {5'd3, 16'b101_0000000000000},
        {5'd3, 16'b110_0000000000000},
        {5'd4, 16'b1110_000000000000},
        {5'd5, 16'b11110_00000000000},
        {5'd6, 16'b111110_0000000000},
        {5'd7, 16'b1111110_000000000},
        {5'd8, 16'b11111110_00000000},
        {5'd9, 16'b111111110_0000000}
    };

    // chroma DC codes
    localparam huff_pkg::huff_entry_t DC_C [`HUFF_DC_CATS] = '{
        {5'd2,  16'b00_00000000000000},
        {5'd2,  16'b01_00000000000000},
        {5'd2,  16'b10_00000000000000},
        {5'd3,  16'b110_0000000000000},
        {5'd4,  16'b1110_000000000000},
        {5'd5,  16'b11110_00000000000},
        {5'd6,  16'b111110_0000000000},
        {5'd7,  16'b1111110_000000000},
        {5'd8,  16'b11111110_00000000},
        {5'd9,  16'b111111110_0000000},
        {5'd10, 16'b1111111110_000000},
        {5'd11, 16'b11111111110_00000}  // longest DC code
    };

    always_comb begin
        for (int i = 0; i < `HUFF_LANES; i++) begin
            if (size[i] > `HUFF_DC_MAX) begin
                entry[i] = '0; // no such category
            end else if (chroma) begin
                entry[i] = DC_C[size[i]];
            end else begin
                entry[i] = DC_Y[size[i]];
            end
        end
    end

endmodule

//--- huff_ac_table.sv
`timescale 1ns/1ps
`include "huff_defs.svh"

module huff_ac_table (
    input  huff_pkg::nibble_lanes_t run,
    input  huff_pkg::nibble_lanes_t size,
    input  logic                    chroma,
    output huff_pkg::entry_lanes_t  entry,
    output huff_pkg::flag_lanes_t   ac_miss
);

    // key is {chroma, size, run}, only the short codes are kept
    function automatic huff_pkg::huff_entry_t ac_lookup(
        input logic [`HUFF_AC_KEY_W-1:0] key
    );
        huff_pkg::huff_entry_t e;
        case (key)
            // luma
            9'h010: e = {5'd2, 16'b00_00000000000000};
            9'h020: e = {5'd2, 16'b01_00000000000000};
            9'h030: e = {5'd3, 16'b100_0000000000000};
            9'h000: e = {5'd4, 16'b1010_000000000000}; // EOB
            9'h040: e = {5'd4, 16'b1011_000000000000};
            9'h011: e = {5'd4, 16'b1100_000000000000};
            9'h050: e = {5'd5, 16'b11010_00000000000};
            9'h021: e = {5'd5, 16'b11011_00000000000};
            9'h012: e = {5'd5, 16'b11100_00000000000};
            9'h013: e = {5'd6, 16'b111010_0000000000};
            9'h014: e = {5'd6, 16'b111011_0000000000};
            9'h060: e = {5'd7, 16'b1111000_000000000};
            9'h031: e = {5'd7, 16'b1111001_000000000};
            9'h015: e = {5'd7, 16'b1111010_000000000};
            9'h016: e = {5'd7, 16'b1111011_000000000};
            9'h070: e = {5'd8, 16'b11111000_00000000};
            9'h022: e = {5'd8, 16'b11111001_00000000};
            9'h017: e = {5'd8, 16'b11111010_00000000};
            // chroma
            9'h100: e = {5'd2, 16'b00_00000000000000}; // EOB
            9'h110: e = {5'd2, 16'b01_00000000000000};
            9'h120: e = {5'd3, 16'b100_0000000000000};
            9'h130: e = {5'd4, 16'b1010_000000000000};
            9'h111: e = {5'd4, 16'b1011_000000000000};
            9'h140: e = {5'd5, 16'b11000_00000000000};
            9'h150: e = {5'd5, 16'b11001_00000000000};
            9'h112: e = {5'd5, 16'b11010_00000000000};
            9'h113: e = {5'd5, 16'b11011_00000000000};
            9'h160: e = {5'd6, 16'b111000_0000000000};
            9'h121: e = {5'd6, 16'b111001_0000000000};
            9'h114: e = {5'd6, 16'b111010_0000000000};
            9'h115: e = {5'd6, 16'b111011_0000000000};
            9'h170: e = {5'd7, 16'b1111000_000000000};
            9'h116: e = {5'd7, 16'b1111001_000000000};
            9'h117: e = {5'd7, 16'b1111010_000000000};
            9'h131: e = {5'd8, 16'b11110110_00000000};
            9'h122: e = {5'd8, 16'b11110111_00000000};
            9'h123: e = {5'd8, 16'b11111000_00000000};
            9'h118: e = {5'd8, 16'b11111001_00000000};
            // ZRL, 10 bits but kept for chroma
            9'h10f: e = {5'd10, 16'b1111111010_000000};
            default: e = '0;
        endcase
        return e;
    endfunction

    always_comb begin
        for (int i = 0; i < `HUFF_LANES; i++) begin
            entry[i]   = ac_lookup({chroma, size[i], run[i]});
            ac_miss[i] = (entry[i].len == '0); // every kept code is non-empty
        end
    end

endmodule

//--- huff_lane_select.sv
`timescale 1ns/1ps
`include "huff_defs.svh"

module huff_lane_select (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   re,
    input  huff_pkg::flag_lanes_t  ac,
    input  huff_pkg::entry_lanes_t dc_entry,
    input  huff_pkg::entry_lanes_t ac_entry,
    input  huff_pkg::flag_lanes_t  ac_miss,
    output huff_pkg::len_lanes_t   len,
    output huff_pkg::code_lanes_t  code
);

    huff_pkg::entry_lanes_t sel;

    // pick the table per lane
    always_comb begin
        for (int i = 0; i < `HUFF_LANES; i++) begin
            if (!ac[i]) begin
                sel[i] = dc_entry[i];
            end else if (ac_miss[i]) begin
                sel[i] = '0; // key not in the short table
            end else begin
                sel[i] = ac_entry[i];
            end
        end
    end

    // one cycle of latency, hold while re is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `HUFF_LANES; i++) begin
                len[i]  <= '0;
                code[i] <= '0;
            end
        end else if (re) begin
            for (int i = 0; i < `HUFF_LANES; i++) begin
                len[i]  <= sel[i].len;
                code[i] <= sel[i].code;
            end
        end
    end

endmodule

//--- huff_tables.sv
`timescale 1ns/1ps

module huff_tables (
    input  logic                    clk,
    input  logic                    arst_n,
    input  huff_pkg::nibble_lanes_t rl,
    input  huff_pkg::nibble_lanes_t coeff_length,
    input  logic                    re,
    input  logic                    chroma,
    input  huff_pkg::flag_lanes_t   ac,
    output huff_pkg::len_lanes_t    len,
    output huff_pkg::code_lanes_t   code
);

    huff_pkg::entry_lanes_t dc_entry;
    huff_pkg::entry_lanes_t ac_entry;
    huff_pkg::flag_lanes_t  ac_miss;

    // DC uses the size category only
    huff_dc_table u_dc (
        .size   (coeff_length),
        .chroma (chroma),
        .entry  (dc_entry)
    );

    huff_ac_table u_ac (
        .run     (rl),
        .size    (coeff_length),
        .chroma  (chroma),
        .entry   (ac_entry),
        .ac_miss (ac_miss)
    );

    // output registers live here
    huff_lane_select u_sel (
        .clk      (clk),
        .arst_n   (arst_n),
        .re       (re),
        .ac       (ac),
        .dc_entry (dc_entry),
        .ac_entry (ac_entry),
        .ac_miss  (ac_miss),
        .len      (len),
        .code     (code)
    );

endmodule

//--- huff_checker.sv
`timescale 1ns/1ps
`include "huff_defs.svh"

module huff_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  re,
    input  huff_pkg::len_lanes_t  exp_len,
    input  huff_pkg::code_lanes_t exp_code,
    input  huff_pkg::len_lanes_t  len,
    input  huff_pkg::code_lanes_t code,
    output int                    lookups,
    output int                    tests,
    output int                    errors
);

    huff_pkg::len_lanes_t  want_len;   // what the output registers should hold
    huff_pkg::code_lanes_t want_code;
    logic loaded;                      // re was high at the last edge
    int n_lookups = 0;
    int n_tests = 0;
    int n_errors = 0;

    assign lookups = n_lookups;
    assign tests   = n_tests;
    assign errors  = n_errors;

    // expected register, one cycle late and holding while re is low
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loaded <= 1'b0;
            for (int i = 0; i < `HUFF_LANES; i++) begin
                want_len[i]  <= '0;
                want_code[i] <= '0;
            end
        end else begin
            loaded <= re;
            if (re) begin
                for (int i = 0; i < `HUFF_LANES; i++) begin
                    want_len[i]  <= exp_len[i];
                    want_code[i] <= exp_code[i];
                end
            end
        end
    end

    task automatic check_lane(input int i);
        if (len[i] !== want_len[i] || code[i] !== want_code[i]) begin
            n_errors++;
            $display("MISMATCH at %0d ns: lane %0d len %0d code %h, expected len %0d code %h",
                     $time, i, len[i], code[i], want_len[i], want_code[i]);
        end else if (loaded) begin
            $display("lookup %0d lane %0d: len %0d code %h ok",
                     n_lookups, i, len[i], code[i]);
        end
        if (loaded) begin
            n_tests++;
        end
    endtask

    // outputs settled at the falling edge
    always @(negedge clk) begin
        for (int i = 0; i < `HUFF_LANES; i++) begin
            check_lane(i);
        end
        if (loaded) begin
            n_lookups++;
        end
    end

endmodule

//--- tb_huff_tables.sv
`timescale 1ns/1ps
`include "huff_defs.svh"

module tb_huff_tables;

    typedef struct packed {
        logic        chroma;
        logic        ac;
        logic [3:0]  run;
        logic [3:0]  size;
        logic [4:0]  len;
        logic [15:0] bits;   // code right-aligned
    } row_t;

    localparam int N_ROWS  = 53;
    localparam int HOLD_AT = 30;

    // standard JPEG codes as {chroma, ac, run, size, length, code}
    localparam row_t ROWS [N_ROWS] = '{
        {1'b0, 1'b0, 4'd0,  4'd0,  5'd2,  16'b00},
        {1'b0, 1'b0, 4'd0,  4'd1,  5'd3,  16'b010},
        {1'b0, 1'b0, 4'd0,  4'd2,  5'd3,  16'b011},
        {1'b0, 1'b0, 4'd0,  4'd3,  5'd3,  16'b100},
        {1'b0, 1'b0, 4'd5,  4'd4,  5'd3,  16'b101},          // run ignored for DC
        {1'b0, 1'b0, 4'd0,  4'd5,  5'd3,  16'b110},
        {1'b0, 1'b0, 4'd0,  4'd6,  5'd4,  16'b1110},
        {1'b0, 1'b0, 4'd0,  4'd7,  5'd5,  16'b11110},
        {1'b0, 1'b0, 4'd0,  4'd8,  5'd6,  16'b111110},
        {1'b0, 1'b0, 4'd0,  4'd9,  5'd7,  16'b1111110},
        {1'b0, 1'b0, 4'd0,  4'd10, 5'd8,  16'b11111110},
        {1'b0, 1'b0, 4'd0,  4'd11, 5'd9,  16'b111111110},
        {1'b0, 1'b0, 4'd0,  4'd12, 5'd0,  16'b0},
        {1'b0, 1'b0, 4'd0,  4'd15, 5'd0,  16'b0},
        {1'b0, 1'b1, 4'd0,  4'd0,  5'd4,  16'b1010},         // EOB
        {1'b0, 1'b1, 4'd0,  4'd1,  5'd2,  16'b00},
        {1'b0, 1'b1, 4'd0,  4'd3,  5'd3,  16'b100},
        {1'b0, 1'b1, 4'd0,  4'd5,  5'd5,  16'b11010},
        {1'b0, 1'b1, 4'd1,  4'd1,  5'd4,  16'b1100},
        {1'b0, 1'b1, 4'd2,  4'd1,  5'd5,  16'b11100},
        {1'b0, 1'b1, 4'd3,  4'd1,  5'd6,  16'b111010},
        {1'b0, 1'b1, 4'd1,  4'd3,  5'd7,  16'b1111001},
        {1'b0, 1'b1, 4'd0,  4'd7,  5'd8,  16'b11111000},
        {1'b0, 1'b1, 4'd7,  4'd1,  5'd8,  16'b11111010},
        {1'b0, 1'b1, 4'd15, 4'd0,  5'd0,  16'b0},            // luma ZRL is 11 bits
        {1'b0, 1'b1, 4'd0,  4'd8,  5'd0,  16'b0},
        {1'b0, 1'b1, 4'd1,  4'd4,  5'd0,  16'b0},
        {1'b1, 1'b0, 4'd0,  4'd0,  5'd2,  16'b00},
        {1'b1, 1'b0, 4'd0,  4'd1,  5'd2,  16'b01},
        {1'b1, 1'b0, 4'd0,  4'd2,  5'd2,  16'b10},
        {1'b1, 1'b0, 4'd0,  4'd3,  5'd3,  16'b110},
        {1'b1, 1'b0, 4'd0,  4'd4,  5'd4,  16'b1110},
        {1'b1, 1'b0, 4'd0,  4'd5,  5'd5,  16'b11110},
        {1'b1, 1'b0, 4'd0,  4'd6,  5'd6,  16'b111110},
        {1'b1, 1'b0, 4'd0,  4'd7,  5'd7,  16'b1111110},
        {1'b1, 1'b0, 4'd0,  4'd8,  5'd8,  16'b11111110},
        {1'b1, 1'b0, 4'd0,  4'd9,  5'd9,  16'b111111110},
        {1'b1, 1'b0, 4'd0,  4'd10, 5'd10, 16'b1111111110},
        {1'b1, 1'b0, 4'd0,  4'd11, 5'd11, 16'b11111111110},
        {1'b1, 1'b0, 4'd0,  4'd13, 5'd0,  16'b0},
        {1'b1, 1'b1, 4'd0,  4'd0,  5'd2,  16'b00},           // EOB
        {1'b1, 1'b1, 4'd0,  4'd1,  5'd2,  16'b01},
        {1'b1, 1'b1, 4'd1,  4'd1,  5'd4,  16'b1011},
        {1'b1, 1'b1, 4'd2,  4'd1,  5'd5,  16'b11010},
        {1'b1, 1'b1, 4'd1,  4'd2,  5'd6,  16'b111001},
        {1'b1, 1'b1, 4'd6,  4'd1,  5'd7,  16'b1111001},
        {1'b1, 1'b1, 4'd1,  4'd3,  5'd8,  16'b11110110},
        {1'b1, 1'b1, 4'd3,  4'd2,  5'd8,  16'b11111000},
        {1'b1, 1'b1, 4'd8,  4'd1,  5'd8,  16'b11111001},
        {1'b1, 1'b1, 4'd15, 4'd0,  5'd10, 16'b1111111010},   // ZRL
        {1'b1, 1'b1, 4'd0,  4'd8,  5'd0,  16'b0},
        {1'b1, 1'b1, 4'd4,  4'd2,  5'd0,  16'b0},
        {1'b1, 1'b1, 4'd15, 4'd1,  5'd0,  16'b0}
    };

    logic clk = 1'b0;
    logic arst_n;
    logic re;
    logic chroma;
    huff_pkg::nibble_lanes_t rl;
    huff_pkg::nibble_lanes_t coeff_length;
    huff_pkg::flag_lanes_t   ac;
    huff_pkg::len_lanes_t    len;
    huff_pkg::code_lanes_t   code;
    huff_pkg::len_lanes_t    exp_len;
    huff_pkg::code_lanes_t   exp_code;
    logic [31:0] rng = 32'h9430_8c65;
    int issued = 0;
    int lookups;
    int tests;
    int errors;

    always #50 clk = ~clk;

    huff_tables dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .rl           (rl),
        .coeff_length (coeff_length),
        .re           (re),
        .chroma       (chroma),
        .ac           (ac),
        .len          (len),
        .code         (code)
    );

    huff_checker chk0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .re       (re),
        .exp_len  (exp_len),
        .exp_code (exp_code),
        .len      (len),
        .code     (code),
        .lookups  (lookups),
        .tests    (tests),
        .errors   (errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // MSB-align a right-aligned code of n bits
    function automatic logic [15:0] align_code(input logic [4:0] n, input logic [15:0] bits);
        if (n == 5'd0) begin
            return '0;
        end
        return bits << (16 - n);
    endfunction

    // lane 0 gets row i0, the other lanes a random row with the same chroma
    task automatic apply_pair(input int i0, input logic en);
        int idx [`HUFF_LANES];
        idx[0] = i0;
        for (int l = 1; l < `HUFF_LANES; l++) begin
            rng = xorshift32(rng);
            idx[l] = int'(rng % N_ROWS);
            while (ROWS[idx[l]].chroma != ROWS[i0].chroma) begin
                idx[l] = (idx[l] + 1) % N_ROWS;
            end
        end
        @(posedge clk);
        re     <= en;
        chroma <= ROWS[i0].chroma;
        for (int l = 0; l < `HUFF_LANES; l++) begin
            ac[l]           <= ROWS[idx[l]].ac;
            rl[l]           <= ROWS[idx[l]].run;
            coeff_length[l] <= ROWS[idx[l]].size;
            exp_len[l]      <= ROWS[idx[l]].len;
            exp_code[l]     <= align_code(ROWS[idx[l]].len, ROWS[idx[l]].bits);
        end
        if (en) begin
            issued++;
        end
    endtask

    initial begin
        arst_n <= 1'b0;
        re     <= 1'b0;
        chroma <= 1'b0;
        for (int l = 0; l < `HUFF_LANES; l++) begin
            rl[l]           <= '0;
            coeff_length[l] <= '0;
            ac[l]           <= 1'b0;
            exp_len[l]      <= '0;
            exp_code[l]     <= '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        // inputs move with re low, outputs keep the reset value
        apply_pair(0, 1'b0);
        apply_pair(40, 1'b0);
        for (int i = 0; i < N_ROWS; i++) begin
            if (i == HOLD_AT) begin
                for (int h = 0; h < 4; h++) begin
                    apply_pair(N_ROWS - 1 - h, 1'b0); // hold window
                end
            end
            apply_pair(i, 1'b1);
        end
        @(posedge clk);
        re <= 1'b0;
        wait (lookups == issued);
        @(posedge clk);
        $display("%0d lookups, %0d lane checks, %0d errors", lookups, tests, errors);
        if (errors == 0 && tests == issued * `HUFF_LANES) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // one cycle per row plus reset, idle and hold cycles with margin
    initial begin
        #((N_ROWS + 20) * 100);
        $display("timeout: the checker did not see every lookup in time");
        $display("test failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
huff_pkg.sv
huff_dc_table.sv
huff_ac_table.sv
huff_lane_select.sv
huff_tables.sv
huff_checker.sv
tb_huff_tables.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_huff_tables -f build.f

out="$(./obj_dir/Vtb_huff_tables)"
echo "$out"

if grep -qx "test passed" <<< "$out"; then
    exit 0
fi
exit 1
